// File: common/vicTypesPkg.sv
// ----------------------------------------------------------
// Chip model enum, raster position and sync output types
// ----------------------------------------------------------

package vicTypesPkg;

	// Raster coordinate widths
	// X must hold the longest line (520 dots) and Y the tallest frame (312 lines)
	localparam int rasterXWidth = 11;
	localparam int rasterYWidth = 9;

	// Chip model, static while the chip is out of reset
	// The two 6567 parts are NTSC, the 6569 and 6572 are PAL
	typedef enum logic [1:0]
	{
		chip6567R8  = 2'd0,
		chip6567Old = 2'd1,
		chip6569    = 2'd2,
		chip6572    = 2'd3
	} chipModel_t;

	// Beam position, X is the dot within the line and Y the line within the frame
	typedef struct packed
	{
		logic [rasterXWidth-1:0] rasterX;
		logic [rasterYWidth-1:0] rasterY;
	} rasterPos_t;

	// Sync outputs of the timing subsystem
	// cSync is negative going, the other three are active high
	typedef struct packed
	{
		logic hSync;
		logic vSync;
		logic cSync;
		logic burstWindow;
	} syncOut_t;

	// Value the sync register takes in reset, all outputs inactive
	localparam syncOut_t syncIdle = '{
		hSync: 1'b0,
		vSync: 1'b0,
		cSync: 1'b1,
		burstWindow: 1'b0
	};

endpackage

// File: common/syncTimingPkg.sv
// ----------------------------------------------------------
// Per-model video timing constants and lookup functions
// ----------------------------------------------------------

package syncTimingPkg;

	import vicTypesPkg::*;

	// Dots per line for each model
	localparam logic [10:0] lineLen6567R8  = 11'd520;
	localparam logic [10:0] lineLen6567Old = 11'd512;
	localparam logic [10:0] lineLen6569    = 11'd504;
	localparam logic [10:0] lineLen6572    = 11'd520;

	// Lines per frame for each model
	localparam logic [8:0] frameH6567R8  = 9'd263;
	localparam logic [8:0] frameH6567Old = 9'd262;
	localparam logic [8:0] frameH6569    = 9'd312;
	localparam logic [8:0] frameH6572    = 9'd312;

	// Horizontal windows in dots, split by video standard
	localparam logic [10:0] hSyncWidthNtsc = 11'd42;
	localparam logic [10:0] hSyncWidthPal  = 11'd37;
	localparam logic [10:0] eqWidthNtsc    = 11'd19;
	localparam logic [10:0] eqWidthPal     = 11'd18;
	localparam logic [10:0] burstBeginNtsc = 11'd43;
	localparam logic [10:0] burstBeginPal  = 11'd44;
	localparam logic [10:0] burstEndNtsc   = 11'd63;
	localparam logic [10:0] burstEndPal    = 11'd62;

	// Vertical sync lines, both bounds inclusive
	localparam logic [8:0] vSyncFirstNtsc = 9'd3;
	localparam logic [8:0] vSyncLastNtsc  = 9'd5;
	localparam logic [8:0] vSyncFirstPal  = 9'd0;
	localparam logic [8:0] vSyncLastPal   = 9'd2;

	// Vertical interval layout
	// Lines 0 to 2 and 6 to 8 carry equalization, lines 3 to 5 serration
	localparam logic [8:0] vIntervalEnd  = 9'd8;
	localparam logic [8:0] serrFirstLine = 9'd3;
	localparam logic [8:0] serrLastLine  = 9'd5;

	// True for the PAL parts
	function automatic logic isPal(chipModel_t chip);
		return chip inside {chip6569, chip6572};
	endfunction

	function automatic logic [10:0] lineLength(chipModel_t chip);
		case (chip)
			chip6567R8:  return lineLen6567R8;
			chip6567Old: return lineLen6567Old;
			chip6569:    return lineLen6569;
			default:     return lineLen6572;
		endcase
	endfunction

	function automatic logic [8:0] frameHeight(chipModel_t chip);
		case (chip)
			chip6567R8:  return frameH6567R8;
			chip6567Old: return frameH6567Old;
			chip6569:    return frameH6569;
			default:     return frameH6572;
		endcase
	endfunction

	function automatic logic [10:0] hSyncWidth(chipModel_t chip);
		return isPal(chip) ? hSyncWidthPal : hSyncWidthNtsc;
	endfunction

	function automatic logic [10:0] eqWidth(chipModel_t chip);
		return isPal(chip) ? eqWidthPal : eqWidthNtsc;
	endfunction

	function automatic logic [10:0] burstBegin(chipModel_t chip);
		return isPal(chip) ? burstBeginPal : burstBeginNtsc;
	endfunction

	function automatic logic [10:0] burstEnd(chipModel_t chip);
		return isPal(chip) ? burstEndPal : burstEndNtsc;
	endfunction

	function automatic logic [8:0] vSyncFirst(chipModel_t chip);
		return isPal(chip) ? vSyncFirstPal : vSyncFirstNtsc;
	endfunction

	function automatic logic [8:0] vSyncLast(chipModel_t chip);
		return isPal(chip) ? vSyncLastPal : vSyncLastNtsc;
	endfunction

endpackage

// File: src/rasterCounter.sv
// ----------------------------------------------------------
// Raster X/Y counter stepped once per dot clock
// ----------------------------------------------------------

`timescale 1ns/1ps

module rasterCounter
	import vicTypesPkg::*, syncTimingPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  chipModel_t chip,
	output rasterPos_t pos
);

	// ----------------------------------------------------------
	// Wrap points of the selected model
	// ----------------------------------------------------------

	logic [10:0] lineLen;
	logic [8:0]  frameH;
	logic        lastDot;
	logic        lastLine;
	rasterPos_t  posNext;

	// The model only changes in reset so these lookups are quasi static
	assign lineLen = lineLength(chip);
	assign frameH  = frameHeight(chip);

	// Last dot of the line
	// A compare with >= keeps the counter from running away if X ever sits past the end
	assign lastDot = pos.rasterX >= lineLen - 11'd1;

	// Last line of the frame, only meaningful together with lastDot
	assign lastLine = pos.rasterY >= frameH - 9'd1;

	// ----------------------------------------------------------
	// Next position
	// ----------------------------------------------------------

	always_comb
	begin
		posNext = pos;
		if (lastDot)
		begin
			// Start a new line
			posNext.rasterX = '0;
			if (lastLine)
				posNext.rasterY = '0;
			else
				posNext.rasterY = pos.rasterY + 9'd1;
		end
		else
		begin
			// Move the beam one dot to the right
			posNext.rasterX = pos.rasterX + 11'd1;
		end
	end

	// ----------------------------------------------------------
	// Position register
	// ----------------------------------------------------------

	// Reset puts the beam at the top left corner of the frame
	always_ff @(posedge clk)
	begin
		if (rst)
			pos <= '0;
		else
			pos <= posNext;
	end

	// Outside reset the beam must stay inside the frame of the current model
	// A model switch is only legal in reset, which clears the position first
	posInFrame: assert property (
		@(posedge clk) disable iff (rst)
		(pos.rasterX < lineLen) && (pos.rasterY < frameH)
	)
	else
		$error("raster position %0d/%0d outside frame of model %s",
			pos.rasterX, pos.rasterY, chip.name());

endmodule

// File: sync/vblankPulses.sv
// ----------------------------------------------------------
// Equalization and serration pulse trains of the vertical interval
// ----------------------------------------------------------

`timescale 1ns/1ps

module vblankPulses
	import vicTypesPkg::*, syncTimingPkg::*;
(
	input  chipModel_t chip,
	input  rasterPos_t pos,
	output logic       eq,
	output logic       se
);

	// ----------------------------------------------------------
	// Horizontal references
	// ----------------------------------------------------------

	logic [10:0] x;
	logic [10:0] lineLen;
	logic [10:0] halfLine;
	logic [10:0] hsWidth;
	logic [10:0] eqW;

	// Only the dot position matters, both trains repeat every half line
	assign x = pos.rasterX;

	assign lineLen = lineLength(chip);
	assign hsWidth = hSyncWidth(chip);
	assign eqW     = eqWidth(chip);

	// Half-line point where the second pulse of each pair starts
	assign halfLine = lineLen >> 1;

	// ----------------------------------------------------------
	// Equalization pulses
	// ----------------------------------------------------------

	logic eqFirst;
	logic eqSecond;

	// Narrow pulse at the start of the line, roughly half the hSync width
	assign eqFirst = x < eqW;

	// Same pulse again from the half-line point
	assign eqSecond = (x >= halfLine) && (x < halfLine + eqW);

	assign eq = eqFirst || eqSecond;

	// ----------------------------------------------------------
	// Serration pulses
	// ----------------------------------------------------------

	logic seFirst;
	logic seSecond;

	// Broad pulse covering the first half line except a gap of one hSync width
	// The gap sits just ahead of the half-line point
	assign seFirst = x < halfLine - hsWidth;

	// Second broad pulse, with its gap at the end of the line
	assign seSecond = (x >= halfLine) && (x < lineLen - hsWidth);

	assign se = seFirst || seSecond;

endmodule

// File: sync/syncGen.sv
// ----------------------------------------------------------
// Registered hSync, vSync, composite sync and burst window
// ----------------------------------------------------------

`timescale 1ns/1ps

module syncGen
	import vicTypesPkg::*, syncTimingPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  chipModel_t chip,
	input  rasterPos_t pos,
	input  logic       eq,
	input  logic       se,
	output syncOut_t   sync
);

	// ----------------------------------------------------------
	// Line classification
	// ----------------------------------------------------------

	logic [10:0] x;
	logic [8:0]  y;
	logic        vIntervalLine;
	logic        serrLine;

	assign x = pos.rasterX;
	assign y = pos.rasterY;

	// Lines 0 to 8 belong to the vertical interval on every model
	assign vIntervalLine = y <= vIntervalEnd;

	// Middle three lines of the interval carry the serrated vertical pulse
	assign serrLine = (y >= serrFirstLine) && (y <= serrLastLine);

	// ----------------------------------------------------------
	// Window decodes
	// ----------------------------------------------------------

	logic     hSyncWin;
	logic     vSyncWin;
	logic     burstWin;
	syncOut_t syncNext;

	// Horizontal sync occupies the start of each line
	assign hSyncWin = x < hSyncWidth(chip);

	// Vertical sync lines differ between NTSC and PAL
	assign vSyncWin = (y >= vSyncFirst(chip)) && (y <= vSyncLast(chip));

	// Burst follows the back porch and is suppressed in the vertical interval
	assign burstWin = (x >= burstBegin(chip)) && (x < burstEnd(chip)) &&
		(y > vIntervalEnd);

	always_comb
	begin
		syncNext.hSync       = hSyncWin;
		syncNext.vSync       = vSyncWin;
		syncNext.burstWindow = burstWin;

		// Composite sync is active low
		// In the vertical interval it is cut from the half-line pulse trains
		if (vIntervalLine && serrLine)
			syncNext.cSync = ~se;
		else if (vIntervalLine)
			syncNext.cSync = ~eq;
		else
			syncNext.cSync = ~hSyncWin;
	end

	// ----------------------------------------------------------
	// Output register
	// ----------------------------------------------------------

	// Outputs describe the position of the previous cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			sync <= syncIdle;
		else
			sync <= syncNext;
	end

	// Burst starts only after sync has ended, on every model
	burstAfterSync: assert property (
		@(posedge clk) disable iff (rst)
		!(sync.burstWindow && sync.hSync)
	)
	else
		$error("burst window overlaps hSync for model %s", chip.name());

	// The first vSync dot of a frame falls inside a broad or equalizing pulse
	// so composite sync has to be low together with it
	vSyncHasCSync: assert property (
		@(posedge clk) disable iff (rst)
		$rose(sync.vSync) |-> !sync.cSync
	)
	else
		$error("vSync rose without composite sync on line %0d", y);

endmodule

// File: src/videoTiming.sv
// ----------------------------------------------------------
// Video timing top level with counter, pulses and sync
// ----------------------------------------------------------

`timescale 1ns/1ps

module videoTiming
	import vicTypesPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  chipModel_t chip,
	output rasterPos_t pos,
	output syncOut_t   sync
);

	// ----------------------------------------------------------
	// Internal wires
	// ----------------------------------------------------------

	// Half-line pulse trains, valid in the same cycle as pos
	logic eq;
	logic se;

	// Beam position, also the top-level pos output
	rasterCounter uRasterCounter
	(
		.clk  (clk),
		.rst  (rst),
		.chip (chip),
		.pos  (pos)
	);

	// Equalization and serration windows from the current dot
	vblankPulses uVblankPulses
	(
		.chip (chip),
		.pos  (pos),
		.eq   (eq),
		.se   (se)
	);

	// Sync outputs lag pos by one cycle
	syncGen uSyncGen
	(
		.clk  (clk),
		.rst  (rst),
		.chip (chip),
		.pos  (pos),
		.eq   (eq),
		.se   (se),
		.sync (sync)
	);

endmodule

// File: testbench/tbClock.sv
// ----------------------------------------------------------
// Dot clock of 40 ns and a two-cycle power-on reset
// ----------------------------------------------------------

`timescale 1ns/1ps

module tbClock
(
	output logic clk,
	output logic rst
);

	// Free running clock, first rising edge at 20 ns
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Reset covers two rising edges and drops just after the second one
	initial
	begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// File: testbench/videoTimingTb.sv
// ----------------------------------------------------------
// Testbench for the video timing top level with a reference model
// ----------------------------------------------------------

`timescale 1ns/1ps

module videoTimingTb
	import vicTypesPkg::*, syncTimingPkg::*;
;

	// One full frame of every model in dots
	localparam int frameDots = 520 * 263 + 512 * 262 + 504 * 312 + 520 * 312;
	// Power-on reset plus the mid-frame reset and three model switches
	localparam int resetCycles = 2 + 4 * 2;
	localparam int cycleLimit = frameDots + resetCycles + 1000;

	logic       clk;
	logic       porRst;
	logic       holdRst;
	logic       rst;
	chipModel_t chip;
	rasterPos_t pos;
	syncOut_t   sync;

	// Reference state that is updated once per cycle at the falling edge
	logic       tracking = 1'b0;
	logic       rstSeen = 1'b0;
	chipModel_t chipSeen = chip6567R8;
	rasterPos_t expPos;
	syncOut_t   expSync;
	logic       frameEnd;
	int         len;
	int         height;
	int         vSyncDots = 0;
	int         frameWraps = 0;
	int         cycleCount = 0;
	logic [31:0] seed;
	int         preResetCycles;

	tbClock uClock
	(
		.clk (clk),
		.rst (porRst)
	);

	// The DUT sees the power-on reset and the resets of the stimulus
	assign rst = porRst || holdRst;

	videoTiming dut
	(
		.clk  (clk),
		.rst  (rst),
		.chip (chip),
		.pos  (pos),
		.sync (sync)
	);

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Dots per line of each model
	function automatic int dotsPerLine(chipModel_t c);
		case (c)
			chip6567R8:  return 520;
			chip6567Old: return 512;
			chip6569:    return 504;
			default:     return 520;
		endcase
	endfunction

	// Lines per frame of each model
	function automatic int linesPerFrame(chipModel_t c);
		case (c)
			chip6567R8:  return 263;
			chip6567Old: return 262;
			chip6569:    return 312;
			default:     return 312;
		endcase
	endfunction

	// Expected sync word one cycle after the beam sits at p
	function automatic syncOut_t refSync(chipModel_t c, rasterPos_t p);
		syncOut_t s;
		logic pal;
		logic eqOn;
		logic seOn;
		int x;
		int y;
		int lineDots;
		int half;
		int hsW;
		int eqW;
		pal = (c == chip6569) || (c == chip6572);
		x = p.rasterX;
		y = p.rasterY;
		lineDots = dotsPerLine(c);
		half = lineDots / 2;
		hsW = pal ? hSyncWidthPal : hSyncWidthNtsc;
		eqW = pal ? eqWidthPal : eqWidthNtsc;
		// Two narrow pulses per line with one at each half line
		eqOn = (x < eqW) || ((x >= half) && (x < half + eqW));
		// Two broad pulses with a gap of one hSync width before each half line
		seOn = (x < half - hsW) || ((x >= half) && (x < lineDots - hsW));
		s.hSync = x < hsW;
		if (pal)
			s.vSync = (y >= vSyncFirstPal) && (y <= vSyncLastPal);
		else
			s.vSync = (y >= vSyncFirstNtsc) && (y <= vSyncLastNtsc);
		if (y >= 3 && y <= 5)
			s.cSync = !seOn;
		else if (y <= 8)
			s.cSync = !eqOn;
		else
			s.cSync = !s.hSync;
		s.burstWindow = pal ?
			((x >= burstBeginPal) && (x < burstEndPal) && (y > 8)) :
			((x >= burstBeginNtsc) && (x < burstEndNtsc) && (y > 8));
		return s;
	endfunction

	task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAIL time=%0t signal=%s got=%0h expected=%0h",
				$time, name, actual, expected);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// ----------------------------------------------------------
	// Comparison at the falling edge where outputs are stable
	// ----------------------------------------------------------

	always @(negedge clk)
	begin
		len = dotsPerLine(chipSeen);
		height = linesPerFrame(chipSeen);
		frameEnd = 1'b0;
		if (rstSeen)
		begin
			// Reset at the last rising edge puts the beam home and idles sync
			expPos = '0;
			expSync = '{hSync: 1'b0, vSync: 1'b0, cSync: 1'b1, burstWindow: 1'b0};
			vSyncDots = 0;
			tracking = 1'b1;
		end
		else if (tracking)
		begin
			expSync = refSync(chipSeen, expPos);
			if (expPos.rasterX == len - 1)
			begin
				expPos.rasterX = '0;
				if (expPos.rasterY == height - 1)
				begin
					expPos.rasterY = '0;
					frameEnd = 1'b1;
				end
				else
					expPos.rasterY = expPos.rasterY + 9'd1;
			end
			else
				expPos.rasterX = expPos.rasterX + 11'd1;
		end
		if (tracking)
		begin
			checkValue("rasterX", pos.rasterX, expPos.rasterX);
			checkValue("rasterY", pos.rasterY, expPos.rasterY);
			checkValue("hSync", sync.hSync, expSync.hSync);
			checkValue("vSync", sync.vSync, expSync.vSync);
			checkValue("cSync", sync.cSync, expSync.cSync);
			checkValue("burstWindow", sync.burstWindow, expSync.burstWindow);
			checkValue("hSync and burstWindow together", sync.hSync & sync.burstWindow, 0);
			// A whole frame holds exactly three lines of vSync
			if (frameEnd)
			begin
				checkValue("vSync dots per frame", vSyncDots, 3 * len);
				vSyncDots = sync.vSync;
				frameWraps = frameWraps + 1;
			end
			else
				vSyncDots = vSyncDots + sync.vSync;
		end
		rstSeen = rst;
		chipSeen = chip;
	end

	// Ends a run that never reaches its last frame
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("test did not finish before the cycle limit");
			$display("Checks failed");
			$fatal(1);
		end
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------

	// Holds reset for two cycles and changes the model only while it is held
	task resetWithChip(chipModel_t nextChip);
		@(posedge clk);
		#1 holdRst = 1'b1;
		@(posedge clk);
		#1 chip = nextChip;
		@(posedge clk);
		#1 holdRst = 1'b0;
	endtask

	// Returns once the reference has seen a complete frame wrap
	task runFrame();
		int startWraps;
		startWraps = frameWraps;
		wait (frameWraps != startWraps);
	endtask

	initial
	begin
		chip = chip6567R8;
		holdRst = 1'b0;
		seed = 32'h32fb;
		wait (porRst == 1'b0);

		// Cut the first frame short at a random dot
		seed = xorshift(seed);
		preResetCycles = 64 + (seed % 512);
		repeat (preResetCycles) @(posedge clk);
		resetWithChip(chip6567R8);
		runFrame();

		resetWithChip(chip6567Old);
		runFrame();
		resetWithChip(chip6569);
		runFrame();
		resetWithChip(chip6572);
		runFrame();

		$display("All checks passed");
		$finish;
	end

endmodule

// File: src.f
common/vicTypesPkg.sv
common/syncTimingPkg.sv
src/rasterCounter.sv
sync/vblankPulses.sv
sync/syncGen.sv
src/videoTiming.sv
testbench/tbClock.sv
testbench/videoTimingTb.sv
